// File: axi_adapter_config.svh
`ifndef AXI_ADAPTER_CONFIG_SVH
`define AXI_ADAPTER_CONFIG_SVH

// Host side address and request length
`define AXA_ADDR_W 32
`define AXA_LEN_W 32

// Data-mover bytes-to-transfer field
`define AXA_BTT_W 23

// Largest chunk the data mover takes in one command
`define AXA_MAX_BTT 32768

// Entries per channel command queue
`define AXA_FIFO_DEPTH 4

`endif

// File: axi_adapter_pkg.sv
`default_nettype none
`include "axi_adapter_config.svh"

package axi_adapter_pkg;

  typedef logic [`AXA_ADDR_W-1:0] addr_t;
  typedef logic [`AXA_LEN_W-1:0]  len_t;
  typedef logic [`AXA_BTT_W-1:0]  btt_t;

  // 72-bit data-mover command, MSB first
  typedef struct packed {
    logic [3:0] rsvd;   // Reserved
    logic [3:0] tag;    // Command tag
    addr_t      saddr;  // Start address
    logic       drr;    // DRE request
    logic       eof;    // End of frame
    logic [5:0] dsa;    // DRE stream alignment
    logic       incr;   // Incrementing burst
    btt_t       btt;    // Bytes to transfer
  } dm_cmd_t;

  // One request per channel, held by the host while en is high
  typedef struct packed {
    logic  en;
    addr_t addr;
    len_t  len;
  } dma_req_t;

endpackage

`default_nettype wire

// File: dma_cmd_splitter.sv
`default_nettype none
`include "axi_adapter_config.svh"

module dma_cmd_splitter #(
  parameter bit EOF_ON_LAST = 1'b0
) (
  input  wire                       i_pcie_clk,
  input  wire                       i_arst_n,
  input  wire axi_adapter_pkg::dma_req_t i_req,
  input  wire                       i_push_ready,
  output logic                      o_push_valid,
  output axi_adapter_pkg::dm_cmd_t  o_cmd
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_ISSUE,
    S_FINISH
  } state_t;

  localparam axi_adapter_pkg::addr_t ADDR_STEP = `AXA_MAX_BTT;
  localparam axi_adapter_pkg::len_t  LEN_STEP  = `AXA_MAX_BTT;
  localparam axi_adapter_pkg::btt_t  BTT_MAX   = `AXA_MAX_BTT;

  state_t                 state_q;
  state_t                 state_d;
  axi_adapter_pkg::addr_t addr_q;   // Working address
  axi_adapter_pkg::addr_t addr_d;
  axi_adapter_pkg::len_t  len_q;    // Bytes still to issue
  axi_adapter_pkg::len_t  len_d;
  logic                   last_chunk;
  logic                   push_fire;

  assign last_chunk   = (len_q <= LEN_STEP);
  assign o_push_valid = (state_q == S_ISSUE);
  assign push_fire    = o_push_valid & i_push_ready;

  always_comb
  begin
    state_d = state_q;
    addr_d  = addr_q;
    len_d   = len_q;
    case (state_q)
      S_IDLE:
      begin
        if (i_req.en)
        begin
          addr_d  = i_req.addr;
          len_d   = i_req.len;
          state_d = S_ISSUE;
        end
      end
      S_ISSUE:
      begin
        if (push_fire)
        begin
          if (last_chunk)
          begin
            state_d = S_FINISH;
          end
          else
          begin
            addr_d = addr_q + ADDR_STEP;  // Next chunk presented right away
            len_d  = len_q - LEN_STEP;
          end
        end
      end
      S_FINISH:
      begin
        if (!i_req.en)
        begin
          state_d = S_IDLE;               // Rearm only after en drops
        end
      end
      default:
      begin
        state_d = S_IDLE;
      end
    endcase
  end

  always_ff @(posedge i_pcie_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      state_q <= S_IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge i_pcie_clk)
  begin
    addr_q <= addr_d;
    len_q  <= len_d;
  end

  // Command is a pure function of the working registers, so it is stable
  // for as long as the push is stalled
  always_comb
  begin
    o_cmd       = '0;
    o_cmd.rsvd  = 4'h0;
    o_cmd.tag   = 4'h0;
    o_cmd.saddr = addr_q;
    o_cmd.drr   = 1'b0;
    o_cmd.eof   = EOF_ON_LAST & last_chunk;  // Read channel only
    o_cmd.dsa   = 6'd0;
    o_cmd.incr  = 1'b1;
    o_cmd.btt   = last_chunk ? len_q[`AXA_BTT_W-1:0] : BTT_MAX;
  end

endmodule

`default_nettype wire

// File: dma_cmd_fifo.sv
`default_nettype none
`include "axi_adapter_config.svh"

module dma_cmd_fifo #(
  parameter int unsigned DEPTH = `AXA_FIFO_DEPTH
) (
  input  wire                      i_pcie_clk,
  input  wire                      i_arst_n,
  input  wire                      i_push_valid,
  input  wire axi_adapter_pkg::dm_cmd_t i_push_cmd,
  output logic                     o_push_ready,
  output logic                     o_pop_valid,
  input  wire                      i_pop_ready,
  output axi_adapter_pkg::dm_cmd_t o_pop_cmd
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

  axi_adapter_pkg::dm_cmd_t mem [DEPTH];
  logic [PTR_W-1:0]         wr_ptr;
  logic [PTR_W-1:0]         rd_ptr;
  logic [CNT_W-1:0]         count;
  logic                     push_fire;
  logic                     pop_fire;

  assign o_pop_valid  = (count != '0);
  assign o_pop_cmd    = mem[rd_ptr];
  assign o_push_ready = (count != FULL_CNT) | i_pop_ready;  // Pass-through when full
  assign push_fire    = i_push_valid & o_push_ready;
  assign pop_fire     = o_pop_valid & i_pop_ready;

  always_ff @(posedge i_pcie_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push_fire)
      begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_fire)
      begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      case ({push_fire, pop_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge i_pcie_clk)
  begin
    if (push_fire)
    begin
      mem[wr_ptr] <= i_push_cmd;
    end
  end

endmodule

`default_nettype wire

// File: axi_adapter.sv
`default_nettype none
`include "axi_adapter_config.svh"

module axi_adapter (
  input  wire                       i_pcie_clk,
  input  wire                       i_arst_n,
  input  wire axi_adapter_pkg::dma_req_t i_wr_req,   // System to user
  input  wire axi_adapter_pkg::dma_req_t i_rd_req,   // User to system
  output axi_adapter_pkg::dm_cmd_t  o_wr_cmd,
  output logic                      o_wr_cmd_valid,
  input  wire                       i_wr_cmd_ready,
  output axi_adapter_pkg::dm_cmd_t  o_rd_cmd,
  output logic                      o_rd_cmd_valid,
  input  wire                       i_rd_cmd_ready
);

  axi_adapter_pkg::dm_cmd_t wr_push_cmd;
  logic                     wr_push_valid;
  logic                     wr_push_ready;
  axi_adapter_pkg::dm_cmd_t rd_push_cmd;
  logic                     rd_push_valid;
  logic                     rd_push_ready;

  dma_cmd_splitter #(.EOF_ON_LAST(1'b0)) u_wr_splitter (
    .i_pcie_clk   (i_pcie_clk),
    .i_arst_n     (i_arst_n),
    .i_req        (i_wr_req),
    .i_push_ready (wr_push_ready),
    .o_push_valid (wr_push_valid),
    .o_cmd        (wr_push_cmd)
  );

  dma_cmd_fifo #(.DEPTH(`AXA_FIFO_DEPTH)) u_wr_fifo (
    .i_pcie_clk   (i_pcie_clk),
    .i_arst_n     (i_arst_n),
    .i_push_valid (wr_push_valid),
    .i_push_cmd   (wr_push_cmd),
    .o_push_ready (wr_push_ready),
    .o_pop_valid  (o_wr_cmd_valid),
    .i_pop_ready  (i_wr_cmd_ready),
    .o_pop_cmd    (o_wr_cmd)
  );

  dma_cmd_splitter #(.EOF_ON_LAST(1'b1)) u_rd_splitter (  // EOF on last read chunk
    .i_pcie_clk   (i_pcie_clk),
    .i_arst_n     (i_arst_n),
    .i_req        (i_rd_req),
    .i_push_ready (rd_push_ready),
    .o_push_valid (rd_push_valid),
    .o_cmd        (rd_push_cmd)
  );

  dma_cmd_fifo #(.DEPTH(`AXA_FIFO_DEPTH)) u_rd_fifo (
    .i_pcie_clk   (i_pcie_clk),
    .i_arst_n     (i_arst_n),
    .i_push_valid (rd_push_valid),
    .i_push_cmd   (rd_push_cmd),
    .o_push_ready (rd_push_ready),
    .o_pop_valid  (o_rd_cmd_valid),
    .i_pop_ready  (i_rd_cmd_ready),
    .o_pop_cmd    (o_rd_cmd)
  );

endmodule

`default_nettype wire

// File: axi_adapter_props.sv
`default_nettype none

module axi_adapter_props (
  input wire                           i_pcie_clk,
  input wire                           i_arst_n,
  input wire                           i_wr_valid,
  input wire                           i_wr_ready,
  input wire axi_adapter_pkg::dm_cmd_t i_wr_cmd,
  input wire                           i_rd_valid,
  input wire                           i_rd_ready,
  input wire axi_adapter_pkg::dm_cmd_t i_rd_cmd
);

  timeunit 1ns;
  timeprecision 100ps;

  a_wr_reset_low: assert property (@(posedge i_pcie_clk) !i_arst_n |-> !i_wr_valid)
    else $error("write valid high during reset");

  a_rd_reset_low: assert property (@(posedge i_pcie_clk) !i_arst_n |-> !i_rd_valid)
    else $error("read valid high during reset");

  // Valid may only drop after a transfer
  a_wr_valid_hold: assert property (@(posedge i_pcie_clk) disable iff (!i_arst_n)
    i_wr_valid && !i_wr_ready |=> i_wr_valid)
    else $error("write valid dropped before transfer");

  a_rd_valid_hold: assert property (@(posedge i_pcie_clk) disable iff (!i_arst_n)
    i_rd_valid && !i_rd_ready |=> i_rd_valid)
    else $error("read valid dropped before transfer");

  a_wr_cmd_stable: assert property (@(posedge i_pcie_clk) disable iff (!i_arst_n)
    i_wr_valid && !i_wr_ready |=> $stable(i_wr_cmd))
    else $error("write command changed while stalled");

  a_rd_cmd_stable: assert property (@(posedge i_pcie_clk) disable iff (!i_arst_n)
    i_rd_valid && !i_rd_ready |=> $stable(i_rd_cmd))
    else $error("read command changed while stalled");

endmodule

bind axi_adapter axi_adapter_props u_axi_adapter_props (
  .i_pcie_clk (i_pcie_clk),
  .i_arst_n   (i_arst_n),
  .i_wr_valid (o_wr_cmd_valid),
  .i_wr_ready (i_wr_cmd_ready),
  .i_wr_cmd   (o_wr_cmd),
  .i_rd_valid (o_rd_cmd_valid),
  .i_rd_ready (i_rd_cmd_ready),
  .i_rd_cmd   (o_rd_cmd)
);

`default_nettype wire

// File: tb_axi_adapter.sv
`default_nettype none
`include "axi_adapter_config.svh"

module tb_axi_adapter;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned MAX_CHUNK      = `AXA_MAX_BTT;
  localparam int unsigned TIMEOUT_CYCLES = 4000;  // Tests need a few hundred cycles

  logic                      i_pcie_clk;
  logic                      i_arst_n;
  axi_adapter_pkg::dma_req_t i_wr_req;
  axi_adapter_pkg::dma_req_t i_rd_req;
  logic                      i_wr_cmd_ready = 1'b0;
  logic                      i_rd_cmd_ready = 1'b0;
  axi_adapter_pkg::dm_cmd_t  o_wr_cmd;
  logic                      o_wr_cmd_valid;
  axi_adapter_pkg::dm_cmd_t  o_rd_cmd;
  logic                      o_rd_cmd_valid;

  axi_adapter_pkg::dm_cmd_t  wr_exp_q[$];
  axi_adapter_pkg::dm_cmd_t  rd_exp_q[$];
  int unsigned               rx_cnt[2] = '{0, 0};      // Transfers seen, index 1 is read
  logic                      stalled[2] = '{1'b0, 1'b0};
  axi_adapter_pkg::dm_cmd_t  held_cmd[2];
  logic                      rand_ready;
  logic [31:0]               rng_state = 32'd58676;
  int unsigned               mon_errs = 0;
  int unsigned               seq_errs;
  int unsigned               test_cnt;
  int unsigned               test_fails;
  int unsigned               test_err_base;
  string                     test_name;
  int unsigned               cycle_cnt;

  axi_adapter i_axi_adapter (
    .i_pcie_clk     (i_pcie_clk),
    .i_arst_n       (i_arst_n),
    .i_wr_req       (i_wr_req),
    .i_rd_req       (i_rd_req),
    .o_wr_cmd       (o_wr_cmd),
    .o_wr_cmd_valid (o_wr_cmd_valid),
    .i_wr_cmd_ready (i_wr_cmd_ready),
    .o_rd_cmd       (o_rd_cmd),
    .o_rd_cmd_valid (o_rd_cmd_valid),
    .i_rd_cmd_ready (i_rd_cmd_ready)
  );

  initial
  begin
    i_pcie_clk = 1'b0;
    forever #2 i_pcie_clk = ~i_pcie_clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int unsigned chunk_count(input axi_adapter_pkg::len_t len);
    return (len + MAX_CHUNK - 1) / MAX_CHUNK;
  endfunction

  // Expected command for chunk k of a request
  function automatic axi_adapter_pkg::dm_cmd_t ref_cmd(input axi_adapter_pkg::addr_t start,
                                                       input axi_adapter_pkg::len_t len,
                                                       input int unsigned k,
                                                       input bit is_rd);
    axi_adapter_pkg::dm_cmd_t c;
    int unsigned              remain;
    remain  = len - k * MAX_CHUNK;
    c       = '0;
    c.saddr = start + axi_adapter_pkg::addr_t'(k * MAX_CHUNK);
    c.btt   = (remain > MAX_CHUNK) ? axi_adapter_pkg::btt_t'(MAX_CHUNK)
                                   : axi_adapter_pkg::btt_t'(remain);
    c.eof   = is_rd && (remain <= MAX_CHUNK);
    c.incr  = 1'b1;
    return c;
  endfunction

  task automatic check_cmd(input axi_adapter_pkg::dm_cmd_t got,
                           input axi_adapter_pkg::dm_cmd_t exp, input string chan);
    if (got !== exp)
    begin
      mon_errs++;
      $display("ERROR %0t: %s command got %h (btt=%0d eof=%b), expected %h (btt=%0d eof=%b)",
               $time, chan, got, got.btt, got.eof, exp, exp.btt, exp.eof);
    end
  endtask

  task automatic check_count(input int unsigned got, input int unsigned exp, input string what);
    if (got != exp)
    begin
      seq_errs++;
      $display("ERROR %0t: %s gave %0d commands, expected %0d", $time, what, got, exp);
    end
  endtask

  // One channel, sampled at the falling edge ahead of the transfer edge
  task automatic observe(input bit is_rd, input logic valid, input logic ready,
                         input axi_adapter_pkg::dm_cmd_t cmd);
    axi_adapter_pkg::dm_cmd_t exp;
    logic                     have_exp;
    string                    chan;
    chan     = is_rd ? "read" : "write";
    have_exp = 1'b0;
    if (!i_arst_n)
    begin
      stalled[is_rd] = 1'b0;
      if (valid)
      begin
        mon_errs++;
        $display("The %s command valid is high during reset at %0t", chan, $time);
      end
    end
    else
    begin
      if (stalled[is_rd] && !(valid && cmd === held_cmd[is_rd]))
      begin
        mon_errs++;
        $display("The %s command was dropped or changed while stalled at %0t", chan, $time);
      end
      if (valid && ready)
      begin
        if (is_rd && rd_exp_q.size() > 0)
        begin
          exp      = rd_exp_q.pop_front();
          have_exp = 1'b1;
        end
        else if (!is_rd && wr_exp_q.size() > 0)
        begin
          exp      = wr_exp_q.pop_front();
          have_exp = 1'b1;
        end
        if (have_exp)
        begin
          check_cmd(cmd, exp, chan);
        end
        else
        begin
          mon_errs++;
          $display("A %s command arrived when none was expected at %0t", chan, $time);
        end
        rx_cnt[is_rd]++;
      end
      stalled[is_rd]  = valid && !ready;
      held_cmd[is_rd] = cmd;
    end
  endtask

  always @(negedge i_pcie_clk)
  begin
    observe(1'b0, o_wr_cmd_valid, i_wr_cmd_ready, o_wr_cmd);
    observe(1'b1, o_rd_cmd_valid, i_rd_cmd_ready, o_rd_cmd);
  end

  always @(posedge i_pcie_clk)
  begin
    if (rand_ready)
    begin
      rng_state = xorshift32(rng_state);
      i_wr_cmd_ready <= rng_state[3];
      i_rd_cmd_ready <= rng_state[17];
    end
    else
    begin
      i_wr_cmd_ready <= 1'b1;
      i_rd_cmd_ready <= 1'b1;
    end
  end

  task automatic start_req(input bit is_rd, input axi_adapter_pkg::addr_t addr,
                           input axi_adapter_pkg::len_t len);
    axi_adapter_pkg::dma_req_t req;
    int unsigned               k;
    for (k = 0; k < chunk_count(len); k++)
    begin
      if (is_rd)
        rd_exp_q.push_back(ref_cmd(addr, len, k, 1'b1));
      else
        wr_exp_q.push_back(ref_cmd(addr, len, k, 1'b0));
    end
    req.en   = 1'b1;
    req.addr = addr;
    req.len  = len;
    @(posedge i_pcie_clk);
    if (is_rd)
      i_rd_req <= req;
    else
      i_wr_req <= req;
  endtask

  task automatic drop_req(input bit is_rd);
    @(posedge i_pcie_clk);
    if (is_rd)
      i_rd_req.en <= 1'b0;
    else
      i_wr_req.en <= 1'b0;
  endtask

  task automatic wait_cmds(input bit is_rd, input int unsigned target);
    while (rx_cnt[is_rd] < target)
      @(posedge i_pcie_clk);
  endtask

  task automatic idle_cycles(input int unsigned n);
    repeat (n) @(posedge i_pcie_clk);
  endtask

  task automatic run_one(input bit is_rd, input axi_adapter_pkg::addr_t addr,
                         input axi_adapter_pkg::len_t len);
    int unsigned base;
    base = rx_cnt[is_rd];
    start_req(is_rd, addr, len);
    wait_cmds(is_rd, base + chunk_count(len));
    drop_req(is_rd);
    idle_cycles(4);  // Room for a stray extra command
    check_count(rx_cnt[is_rd] - base, chunk_count(len), is_rd ? "read request" : "write request");
  endtask

  task automatic begin_test(input string name);
    test_cnt++;
    test_name     = name;
    test_err_base = mon_errs + seq_errs;
  endtask

  task automatic end_test;
    if (mon_errs + seq_errs == test_err_base)
    begin
      $display("test %0d %s: ok", test_cnt, test_name);
    end
    else
    begin
      test_fails++;
      $display("test %0d %s: FAILED, %0d errors", test_cnt, test_name,
               mon_errs + seq_errs - test_err_base);
    end
  endtask

  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES)
    begin
      @(posedge i_pcie_clk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, the DUT stopped issuing expected commands", cycle_cnt);
    $display("sim failed");
    $finish;
  end

  initial
  begin
    int unsigned base_wr;
    int unsigned base_rd;
    i_arst_n   = 1'b0;
    i_wr_req   = '0;
    i_rd_req   = '0;
    rand_ready = 1'b0;
    seq_errs   = 0;
    test_cnt   = 0;
    test_fails = 0;
    idle_cycles(8);
    i_arst_n <= 1'b1;
    idle_cycles(2);

    begin_test("short write");
    run_one(1'b0, 32'h1000_0000, 32'd1500);
    end_test();

    begin_test("long read");
    run_one(1'b1, 32'h2000_0000, 32'd100000);  // Last chunk 1696 bytes
    end_test();

    begin_test("exact multiple");
    run_one(1'b1, 32'h3000_0000, 32'd98304);
    end_test();

    begin_test("random back-pressure");
    rand_ready <= 1'b1;
    run_one(1'b0, 32'h4000_0000, 32'd200000);
    run_one(1'b1, 32'h4800_0000, 32'd150000);
    rand_ready <= 1'b0;
    end_test();

    begin_test("en held after completion");
    base_wr = rx_cnt[0];
    start_req(1'b0, 32'h5000_0000, 32'd40000);
    wait_cmds(1'b0, base_wr + 2);
    idle_cycles(20);
    check_count(rx_cnt[0] - base_wr, 2, "held write request");
    drop_req(1'b0);
    idle_cycles(2);
    run_one(1'b0, 32'h5800_0000, 32'd512);
    end_test();

    begin_test("concurrent channels");
    rand_ready <= 1'b1;
    base_wr = rx_cnt[0];
    base_rd = rx_cnt[1];
    start_req(1'b0, 32'h6000_0000, 32'd70000);
    start_req(1'b1, 32'h7000_0000, 32'd131072);
    wait_cmds(1'b0, base_wr + 3);
    wait_cmds(1'b1, base_rd + 4);
    drop_req(1'b0);
    drop_req(1'b1);
    idle_cycles(6);
    check_count(rx_cnt[0] - base_wr, 3, "concurrent write");
    check_count(rx_cnt[1] - base_rd, 4, "concurrent read");
    end_test();

    $display("%0d tests, %0d failed, %0d errors", test_cnt, test_fails, mon_errs + seq_errs);
    if (mon_errs + seq_errs == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+.
axi_adapter_pkg.sv
dma_cmd_splitter.sv
dma_cmd_fifo.sv
axi_adapter.sv
axi_adapter_props.sv
tb_axi_adapter.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       = tb_axi_adapter
FLIST     = flist.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SIM_ARGS  = +verilator+error+limit+100
PASS_MSG  = sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(SIM) $(SIM_ARGS))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
